// File: logic/obj_pkg.sv
package obj_pkg;

    // screen and tile geometry
    localparam int TILE_SIZE     = 16;
    localparam int TILE_BEATS    = 32;
    localparam int ROW_SLOTS     = 20;
    localparam int WORDS_PER_ROW = 5;

    // coordinates wrap at 12 bits
    typedef logic [11:0] coord_t;
    typedef logic [5:0]  pixel_t;
    typedef logic [63:0] fb_word_t;
    typedef logic [7:0]  fb_be_t;
    typedef logic [14:0] fb_addr_t;
    typedef logic [7:0]  color_t;
    typedef logic [13:0] tile_code_t;

    // largest visible position, unsigned compare
    localparam coord_t X_LIMIT = 12'd480;
    localparam coord_t Y_LIMIT = 12'd240;

    // x word flags
    localparam int X_LATCH_EXTRA  = 12;
    localparam int X_LATCH_MASTER = 13;
    localparam int X_NO_EXTRA     = 14;
    localparam int X_ABSOLUTE     = 15;

    // attribute word flags
    localparam int A_FLIP_X      = 8;
    localparam int A_REUSE_COLOR = 10;
    localparam int A_USE_LATCH_Y = 12;
    localparam int A_Y_PLUS16    = 13;
    localparam int A_USE_LATCH_X = 14;
    localparam int A_X_PLUS16    = 15;

endpackage

// File: logic/obj_ifaces.sv
`timescale 1ns/1ps

// one evaluated sprite, ready to draw
interface draw_cmd_if;
    import obj_pkg::*;

    logic       valid;
    logic       ready;
    coord_t     x;
    coord_t     y;
    logic       flip_x;
    color_t     color;
    tile_code_t tile_code;

    modport source (output valid, x, y, flip_x, color, tile_code, input ready);
    modport sink (input valid, x, y, flip_x, color, tile_code, output ready);
endinterface

// row lookup into the decoded tile
interface pixel_row_if;
    import obj_pkg::*;

    logic [3:0] row;
    pixel_t     pixels [TILE_SIZE];
    logic       loaded;

    modport store (input row, output pixels, loaded);
    modport packer (output row, input pixels);
endinterface

// File: logic/obj_position_eval.sv
`timescale 1ns/1ps

module obj_position_eval (
    input  logic        clk,
    input  logic        reset,
    input  logic        entry_valid,
    output logic        entry_ready,
    input  logic [15:0] tile_word,
    input  logic [15:0] attr_word,
    input  logic [15:0] x_word,
    input  logic [15:0] y_word,
    draw_cmd_if.source  cmd
);
    import obj_pkg::*;

    coord_t     master_x, master_y;
    coord_t     extra_x, extra_y;
    coord_t     latch_x, latch_y;
    color_t     latch_color;
    logic       pending;
    logic       flip_x_q;
    tile_code_t tile_code_q;
    coord_t     base_x, base_y;
    coord_t     next_x, next_y;
    logic       draw;
    logic       take;

    // no new entry until the drawer is idle again
    assign entry_ready = !pending && cmd.ready;
    assign take = entry_valid && entry_ready;

    always_comb begin
        base_x = x_word[11:0];
        base_y = y_word[11:0];
        if (!x_word[X_ABSOLUTE]) begin
            base_x = base_x + master_x;
            base_y = base_y + master_y;
            if (!x_word[X_NO_EXTRA]) begin
                base_x = base_x + extra_x;
                base_y = base_y + extra_y;
            end
        end
        next_x = attr_word[A_USE_LATCH_X] ? latch_x : base_x;
        next_y = attr_word[A_USE_LATCH_Y] ? latch_y : base_y;
        if (attr_word[A_X_PLUS16]) begin
            next_x = next_x + 12'd16;
        end
        if (attr_word[A_Y_PLUS16]) begin
            next_y = next_y + 12'd16;
        end
        // cull empty tiles and off-screen positions
        draw = (tile_word[13:0] != '0) && (next_x <= X_LIMIT) && (next_y <= Y_LIMIT);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            master_x <= '0;
            master_y <= '0;
            extra_x <= '0;
            extra_y <= '0;
            latch_x <= '0;
            latch_y <= '0;
            latch_color <= '0;
            pending <= 1'b0;
        end else if (take) begin
            if (x_word[X_LATCH_EXTRA]) begin
                extra_x <= base_x;
                extra_y <= base_y;
            end
            if (x_word[X_LATCH_MASTER]) begin
                master_x <= base_x;
                master_y <= base_y;
            end
            latch_x <= next_x;
            latch_y <= next_y;
            if (!attr_word[A_REUSE_COLOR]) begin
                latch_color <= attr_word[7:0];
            end
            pending <= draw;
        end else if (cmd.ready) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            flip_x_q <= attr_word[A_FLIP_X];
            tile_code_q <= tile_word[13:0];
        end
    end

    assign cmd.valid = pending;
    assign cmd.x = latch_x;
    assign cmd.y = latch_y;
    assign cmd.flip_x = flip_x_q;
    assign cmd.color = latch_color;
    assign cmd.tile_code = tile_code_q;

endmodule

// File: logic/obj_tile_store.sv
`timescale 1ns/1ps

module obj_tile_store (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic             tile_valid,
    input  obj_pkg::fb_word_t tile_data,
    pixel_row_if.store       rows
);
    import obj_pkg::*;

    localparam int BEAT_W = $clog2(TILE_BEATS);

    pixel_t            pixel_mem [TILE_SIZE * TILE_SIZE];
    logic [BEAT_W-1:0] beat;
    logic              loaded;

    // low nibble from the bottom half, top two bits from bits 23:16
    function automatic pixel_t decode_6bpp(input logic [31:0] half, input int k);
        return {half[16 + 2 * k +: 2], half[4 * k +: 4]};
    endfunction

    // eight pixels per beat, four from each 32-bit half
    always_ff @(posedge clk) begin
        if (tile_valid) begin
            for (int k = 0; k < 8; k++) begin
                pixel_mem[{beat, 3'(k)}] <= decode_6bpp(tile_data[32 * (k / 4) +: 32], k % 4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || start) begin
            beat <= '0;
            loaded <= 1'b0;
        end else if (tile_valid) begin
            beat <= beat + 1'b1;
            if (beat == BEAT_W'(TILE_BEATS - 1)) begin
                loaded <= 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < TILE_SIZE; i++) begin
            rows.pixels[i] = pixel_mem[{rows.row, 4'(i)}];
        end
    end

    assign rows.loaded = loaded;

endmodule

// File: logic/obj_row_packer.sv
`timescale 1ns/1ps

module obj_row_packer (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  obj_pkg::coord_t   x,
    input  obj_pkg::coord_t   y,
    input  logic              flip_x,
    input  obj_pkg::color_t   color,
    input  logic              advance,
    pixel_row_if.packer       rows,
    output obj_pkg::fb_addr_t fb_addr,
    output obj_pkg::fb_word_t fb_data,
    output obj_pkg::fb_be_t   fb_be,
    output logic              word_valid,
    output logic              last
);
    import obj_pkg::*;

    pixel_t     slots [ROW_SLOTS];
    pixel_t     fresh [ROW_SLOTS];
    logic [3:0] row;
    logic [2:0] col;
    logic       row_end;

    assign row_end = col == 3'(WORDS_PER_ROW - 1);
    assign last = word_valid && row_end && (row == 4'(TILE_SIZE - 1));

    // before the first word fetch row 0, afterwards the one after the current row
    assign rows.row = word_valid ? row + 4'd1 : row;

    // flipped row placed at the x[1:0] offset
    always_comb begin
        for (int i = 0; i < ROW_SLOTS; i++) begin
            fresh[i] = '0;
        end
        for (int i = 0; i < TILE_SIZE; i++) begin
            fresh[i + int'(x[1:0])] = flip_x ? rows.pixels[TILE_SIZE - 1 - i] : rows.pixels[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || start) begin
            word_valid <= 1'b0;
            row <= '0;
            col <= '0;
        end else if (advance) begin
            if (!word_valid) begin
                word_valid <= 1'b1;
            end else if (row_end) begin
                col <= '0;
                row <= row + 4'd1;
                if (row == 4'(TILE_SIZE - 1)) begin
                    word_valid <= 1'b0;
                end
            end else begin
                col <= col + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if (!word_valid || row_end) begin
                slots <= fresh;
            end else begin
                // next four dots move to the front
                for (int i = 0; i < ROW_SLOTS - 4; i++) begin
                    slots[i] <= slots[i + 4];
                end
                for (int i = ROW_SLOTS - 4; i < ROW_SLOTS; i++) begin
                    slots[i] <= '0;
                end
            end
        end
    end

    always_comb begin
        for (int d = 0; d < 4; d++) begin
            fb_data[16 * d +: 16] = {4'd0, color[7:2], slots[d]};
            fb_be[2 * d +: 2] = {2{slots[d] != '0}};
        end
    end

    assign fb_addr = {y[7:0] + {4'd0, row}, x[8:2] + {4'd0, col}};

endmodule

// File: logic/obj_draw_ctrl.sv
`timescale 1ns/1ps

module obj_draw_ctrl (
    input  logic                clk,
    input  logic                reset,
    draw_cmd_if.sink            cmd,
    output logic                tile_req,
    output obj_pkg::tile_code_t tile_code,
    output logic                start,
    input  logic                loaded,
    input  logic                word_valid,
    input  logic                last,
    output logic                advance,
    output logic                fb_write,
    input  logic                fb_busy
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REQUEST,
        ST_LOAD_WAIT,
        ST_PRIME,
        ST_WRITE
    } state_t;

    state_t state;
    logic   word_done;

    assign cmd.ready = state == ST_IDLE;
    assign tile_req = state == ST_REQUEST;
    // clears the tile store and the packer for the new sprite
    assign start = state == ST_REQUEST;
    assign fb_write = (state == ST_WRITE) && word_valid;
    assign word_done = fb_write && !fb_busy;
    // prime pulse loads row 0 into the packer
    assign advance = (state == ST_PRIME) || word_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd.valid) begin
                        state <= ST_REQUEST;
                    end
                end
                ST_REQUEST: begin
                    state <= ST_LOAD_WAIT;
                end
                ST_LOAD_WAIT: begin
                    if (loaded) begin
                        state <= ST_PRIME;
                    end
                end
                ST_PRIME: begin
                    state <= ST_WRITE;
                end
                ST_WRITE: begin
                    if (word_done && last) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.valid && cmd.ready) begin
            tile_code <= cmd.tile_code;
        end
    end

endmodule

// File: logic/obj_engine.sv
`timescale 1ns/1ps

module obj_engine (
    input  logic                clk,
    input  logic                reset,
    input  logic                entry_valid,
    output logic                entry_ready,
    input  logic [15:0]         tile_word,
    input  logic [15:0]         attr_word,
    input  logic [15:0]         x_word,
    input  logic [15:0]         y_word,
    output logic                tile_req,
    output obj_pkg::tile_code_t tile_code,
    input  logic                tile_valid,
    input  obj_pkg::fb_word_t   tile_data,
    output logic                fb_write,
    output obj_pkg::fb_addr_t   fb_addr,
    output obj_pkg::fb_word_t   fb_data,
    output obj_pkg::fb_be_t     fb_be,
    input  logic                fb_busy
);

    logic start;
    logic advance;
    logic word_valid;
    logic last;

    draw_cmd_if  cmd_if ();
    pixel_row_if row_if ();

    obj_position_eval obj_position_eval_i (
        .clk         (clk),
        .reset       (reset),
        .entry_valid (entry_valid),
        .entry_ready (entry_ready),
        .tile_word   (tile_word),
        .attr_word   (attr_word),
        .x_word      (x_word),
        .y_word      (y_word),
        .cmd         (cmd_if.source)
    );

    obj_tile_store obj_tile_store_i (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .tile_valid (tile_valid),
        .tile_data  (tile_data),
        .rows       (row_if.store)
    );

    // sprite fields stay put while drawing since entries wait for idle
    obj_row_packer obj_row_packer_i (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .x          (cmd_if.x),
        .y          (cmd_if.y),
        .flip_x     (cmd_if.flip_x),
        .color      (cmd_if.color),
        .advance    (advance),
        .rows       (row_if.packer),
        .fb_addr    (fb_addr),
        .fb_data    (fb_data),
        .fb_be      (fb_be),
        .word_valid (word_valid),
        .last       (last)
    );

    obj_draw_ctrl obj_draw_ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .cmd        (cmd_if.sink),
        .tile_req   (tile_req),
        .tile_code  (tile_code),
        .start      (start),
        .loaded     (row_if.loaded),
        .word_valid (word_valid),
        .last       (last),
        .advance    (advance),
        .fb_write   (fb_write),
        .fb_busy    (fb_busy)
    );

endmodule

// File: sim/obj_engine_assertions.sv
`timescale 1ns/1ps

module obj_engine_assertions (
    input logic              clk,
    input logic              reset,
    input logic              entry_ready,
    input logic              tile_req,
    input logic              fb_write,
    input logic              fb_busy,
    input obj_pkg::fb_addr_t fb_addr,
    input obj_pkg::fb_word_t fb_data,
    input obj_pkg::fb_be_t   fb_be
);

    // failed assertions so far
    int failures = 0;

    // a stalled word is held until it completes
    word_held: assert property (@(posedge clk) disable iff (reset)
        fb_write && fb_busy |=> fb_write && $stable(fb_addr) && $stable(fb_data)
            && $stable(fb_be))
        else begin
            failures++;
            $error("framebuffer word changed while fb_busy was high");
        end

    req_pulse: assert property (@(posedge clk) disable iff (reset)
        tile_req |=> !tile_req)
        else begin
            failures++;
            $error("tile_req lasted more than one cycle");
        end

    // no entries taken while a sprite is being written
    no_entry_in_write: assert property (@(posedge clk) disable iff (reset)
        fb_write |-> !entry_ready)
        else begin
            failures++;
            $error("entry_ready high during a framebuffer write");
        end

endmodule

// File: sim/obj_engine_tb.sv
`timescale 1ns/1ps

module obj_engine_tb;
    import obj_pkg::*;

    localparam int          WAIT_LIMIT       = 2000;
    localparam int          WORDS_PER_SPRITE = 80;
    localparam logic [31:0] SEED             = 32'd59309;

    // entry flag masks
    localparam logic [15:0] ABS          = 16'd1 << X_ABSOLUTE;
    localparam logic [15:0] NO_EXTRA     = 16'd1 << X_NO_EXTRA;
    localparam logic [15:0] LATCH_MASTER = 16'd1 << X_LATCH_MASTER;
    localparam logic [15:0] LATCH_EXTRA  = 16'd1 << X_LATCH_EXTRA;
    localparam logic [15:0] FLIP         = 16'd1 << A_FLIP_X;
    localparam logic [15:0] REUSE        = 16'd1 << A_REUSE_COLOR;
    localparam logic [15:0] LATCH_X      = 16'd1 << A_USE_LATCH_X;
    localparam logic [15:0] LATCH_Y      = 16'd1 << A_USE_LATCH_Y;
    localparam logic [15:0] X16          = 16'd1 << A_X_PLUS16;
    localparam logic [15:0] Y16          = 16'd1 << A_Y_PLUS16;

    typedef struct packed {
        coord_t     x;
        coord_t     y;
        logic       flip_x;
        color_t     color;
        tile_code_t code;
    } sprite_t;

    logic        clk;
    logic        reset;
    logic        entry_valid;
    logic        entry_ready;
    logic [15:0] tile_word;
    logic [15:0] attr_word;
    logic [15:0] x_word;
    logic [15:0] y_word;
    logic        tile_req;
    tile_code_t  tile_code;
    logic        tile_valid;
    fb_word_t    tile_data;
    logic        fb_write;
    fb_addr_t    fb_addr;
    fb_word_t    fb_data;
    fb_be_t      fb_be;
    logic        fb_busy;

    // testbench copy of the scroll and latch state
    coord_t master_x;
    coord_t master_y;
    coord_t extra_x;
    coord_t extra_y;
    coord_t latch_x;
    coord_t latch_y;
    color_t latch_color;

    sprite_t     sprites [$];
    string       sprite_names [$];
    logic [86:0] expected [$];
    string       expected_names [$];
    pixel_t      tile_pix [256];
    string       current_test;
    logic [31:0] entry_rng;
    logic [31:0] tile_rng;
    logic [31:0] busy_rng;
    int          sprites_drawn;
    int          tile_reqs;
    int          words_seen;
    int          value_errors;
    int          other_errors;

    obj_engine obj_engine_i (
        .clk         (clk),
        .reset       (reset),
        .entry_valid (entry_valid),
        .entry_ready (entry_ready),
        .tile_word   (tile_word),
        .attr_word   (attr_word),
        .x_word      (x_word),
        .y_word      (y_word),
        .tile_req    (tile_req),
        .tile_code   (tile_code),
        .tile_valid  (tile_valid),
        .tile_data   (tile_data),
        .fb_write    (fb_write),
        .fb_addr     (fb_addr),
        .fb_data     (fb_data),
        .fb_be       (fb_be),
        .fb_busy     (fb_busy)
    );

    bind obj_engine obj_engine_assertions obj_engine_assertions_i (
        .clk         (clk),
        .reset       (reset),
        .entry_ready (entry_ready),
        .tile_req    (tile_req),
        .fb_write    (fb_write),
        .fb_busy     (fb_busy),
        .fb_addr     (fb_addr),
        .fb_data     (fb_data),
        .fb_be       (fb_be)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // expected {addr, data, be} of word c in tile row r
    function automatic logic [86:0] expected_word(input sprite_t s, input int r, input int c);
        fb_addr_t addr;
        fb_word_t data;
        fb_be_t   be;
        pixel_t   pix;
        int       i;
        int       d;
        addr[14:7] = s.y[7:0] + 8'(r);
        addr[6:0] = s.x[8:2] + 7'(c);
        for (d = 0; d < 4; d++) begin
            i = 4 * c + d - int'(s.x[1:0]);
            pix = '0;
            if (i >= 0 && i < TILE_SIZE) begin
                pix = s.flip_x ? tile_pix[16 * r + 15 - i] : tile_pix[16 * r + i];
            end
            data[16 * d +: 16] = {4'd0, s.color[7:2], pix};
            be[2 * d +: 2] = {2{pix != '0}};
        end
        return {addr, data, be};
    endfunction

    // position rules applied to the testbench state
    task automatic apply_entry(input logic [15:0] tile, input logic [15:0] attr,
                               input logic [15:0] xw, input logic [15:0] yw,
                               output logic drawn);
        coord_t bx;
        coord_t by;
        bx = xw[11:0];
        by = yw[11:0];
        if (!xw[X_ABSOLUTE]) begin
            bx = bx + master_x + (xw[X_NO_EXTRA] ? 12'd0 : extra_x);
            by = by + master_y + (xw[X_NO_EXTRA] ? 12'd0 : extra_y);
        end
        if (xw[X_LATCH_EXTRA]) begin
            extra_x = bx;
            extra_y = by;
        end
        if (xw[X_LATCH_MASTER]) begin
            master_x = bx;
            master_y = by;
        end
        latch_x = (attr[A_USE_LATCH_X] ? latch_x : bx) + (attr[A_X_PLUS16] ? 12'd16 : 12'd0);
        latch_y = (attr[A_USE_LATCH_Y] ? latch_y : by) + (attr[A_Y_PLUS16] ? 12'd16 : 12'd0);
        if (!attr[A_REUSE_COLOR]) begin
            latch_color = attr[7:0];
        end
        drawn = (tile[13:0] != '0) && (latch_x <= 12'd480) && (latch_y <= 12'd240);
    endtask

    task automatic finish_run;
        int assert_errors;
        assert_errors = obj_engine_i.obj_engine_assertions_i.failures;
        $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errors, other_errors, assert_errors);
        if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        other_errors++;
        $display("ERROR: timeout at %0t, %s", $time, what);
        finish_run();
    endtask

    task automatic send_entry(input logic [15:0] tile, input logic [15:0] attr,
                              input logic [15:0] xw, input logic [15:0] yw);
        logic    drawn;
        sprite_t s;
        int      waited;
        apply_entry(tile, attr, xw, yw, drawn);
        if (drawn) begin
            s.x = latch_x;
            s.y = latch_y;
            s.flip_x = attr[A_FLIP_X];
            s.color = latch_color;
            s.code = tile[13:0];
            sprites.push_back(s);
            sprite_names.push_back(current_test);
            sprites_drawn++;
        end
        @(negedge clk);
        tile_word = tile;
        attr_word = attr;
        x_word = xw;
        y_word = yw;
        entry_valid = 1'b1;
        waited = 0;
        while (!entry_ready) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_timeout("entry was never accepted");
            end
        end
        @(negedge clk);
        entry_valid = 1'b0;
    endtask

    // answers one tile_req with random pixels and queues the expected words
    task automatic serve_tile;
        sprite_t  s;
        string    name;
        fb_word_t beat;
        pixel_t   pix;
        int       p;
        int       b;
        int       h;
        int       k;
        int       r;
        int       c;
        int       gap;
        tile_reqs++;
        if (sprites.size() == 0) begin
            other_errors++;
            $display("ERROR: tile_req at %0t without a visible sprite", $time);
            return;
        end
        s = sprites.pop_front();
        name = sprite_names.pop_front();
        if (tile_code != s.code) begin
            value_errors++;
            $display("[FAIL] %s tile_code: expected %h, actual %h", name, s.code, tile_code);
        end
        for (p = 0; p < 256; p++) begin
            tile_rng = xorshift32(tile_rng);
            // about a quarter transparent
            tile_pix[p] = (tile_rng[7:6] == 2'd0) ? 6'd0 : tile_rng[5:0];
        end
        for (r = 0; r < TILE_SIZE; r++) begin
            for (c = 0; c < WORDS_PER_ROW; c++) begin
                expected.push_back(expected_word(s, r, c));
                expected_names.push_back(name);
            end
        end
        for (b = 0; b < TILE_BEATS; b++) begin
            beat = '0;
            for (h = 0; h < 2; h++) begin
                for (k = 0; k < 4; k++) begin
                    pix = tile_pix[8 * b + 4 * h + k];
                    beat[32 * h + 4 * k +: 4] = pix[3:0];
                    beat[32 * h + 16 + 2 * k +: 2] = pix[5:4];
                end
            end
            tile_rng = xorshift32(tile_rng);
            gap = int'(tile_rng % 32'd3);
            @(negedge clk);
            tile_valid = 1'b0;
            repeat (gap) begin
                @(negedge clk);
            end
            tile_valid = 1'b1;
            tile_data = beat;
        end
        @(negedge clk);
        tile_valid = 1'b0;
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (tile_req) begin
                serve_tile();
            end
        end
    end

    // random back-pressure and the comparing process
    initial begin
        logic [86:0] want;
        string       name;
        forever begin
            @(negedge clk);
            busy_rng = xorshift32(busy_rng);
            fb_busy = busy_rng[2:0] < 3'd3;
            if (fb_write && !fb_busy) begin
                words_seen++;
                if (expected.size() == 0) begin
                    other_errors++;
                    $display("ERROR: unexpected framebuffer write to %h at %0t", fb_addr, $time);
                end else begin
                    want = expected.pop_front();
                    name = expected_names.pop_front();
                    if (fb_addr != want[86:72]) begin
                        value_errors++;
                        $display("[FAIL] %s fb_addr: expected %h, actual %h",
                                 name, want[86:72], fb_addr);
                    end
                    if (fb_data != want[71:8]) begin
                        value_errors++;
                        $display("[FAIL] %s fb_data at %h: expected %h, actual %h",
                                 name, fb_addr, want[71:8], fb_data);
                    end
                    if (fb_be != want[7:0]) begin
                        value_errors++;
                        $display("[FAIL] %s fb_be at %h: expected %h, actual %h",
                                 name, fb_addr, want[7:0], fb_be);
                    end
                end
            end
        end
    end

    task automatic wait_drained;
        int waited;
        waited = 0;
        while (words_seen < WORDS_PER_SPRITE * sprites_drawn || !entry_ready) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_timeout("framebuffer writes did not finish");
            end
        end
        // idle window for stray writes
        repeat (20) begin
            @(negedge clk);
        end
    endtask

    initial begin
        int n;
        entry_rng = SEED;
        tile_rng = xorshift32(SEED);
        busy_rng = xorshift32(tile_rng);
        reset = 1'b1;
        entry_valid = 1'b0;
        tile_word = '0;
        attr_word = '0;
        x_word = '0;
        y_word = '0;
        tile_valid = 1'b0;
        tile_data = '0;
        fb_busy = 1'b0;
        master_x = '0;
        master_y = '0;
        extra_x = '0;
        extra_y = '0;
        latch_x = '0;
        latch_y = '0;
        latch_color = '0;
        sprites_drawn = 0;
        tile_reqs = 0;
        words_seen = 0;
        value_errors = 0;
        other_errors = 0;
        repeat (5) begin
            @(negedge clk);
        end
        reset = 1'b0;

        current_test = "absolute";
        send_entry(16'h0001, 16'h005c, ABS | 16'd40, 16'd30);

        current_test = "master scroll";
        send_entry(16'h0000, 16'h0000, ABS | LATCH_MASTER | 16'd100, 16'd20);
        send_entry(16'h0002, 16'h0033, NO_EXTRA | 16'd16, 16'd10);

        current_test = "extra scroll";
        send_entry(16'h0000, 16'h0000, ABS | LATCH_EXTRA | 16'd8, 16'd4);
        send_entry(16'h0003, 16'h0048, 16'd20, 16'd12);
        // same entry with the extra scroll skipped
        send_entry(16'h0010, 16'h0048, NO_EXTRA | 16'd20, 16'd12);

        current_test = "latch plus 16";
        send_entry(16'h0004, LATCH_X | LATCH_Y | X16 | 16'h0021, 16'd0, 16'd0);
        send_entry(16'h0005, LATCH_X | LATCH_Y | X16 | Y16 | REUSE, 16'd0, 16'd0);
        send_entry(16'h0006, LATCH_X | LATCH_Y | X16 | REUSE, 16'd0, 16'd0);

        // culled entries still move the latches
        current_test = "culling";
        send_entry(16'h0000, 16'h0010, ABS | 16'd64, 16'd80);
        send_entry(16'h0007, LATCH_X | LATCH_Y | 16'h0010, 16'd0, 16'd0);
        send_entry(16'h0008, 16'h0010, ABS | 16'd481, 16'd50);
        send_entry(16'h0009, LATCH_Y | 16'h0010, ABS | 16'd300, 16'd0);
        send_entry(16'h000a, 16'h0010, ABS | 16'd20, 16'd241);
        send_entry(16'h000b, LATCH_X | 16'h0010, ABS, 16'd7);
        send_entry(16'h000c, 16'h0066, ABS | 16'd480, 16'd240);

        current_test = "flip and shift";
        send_entry(16'h000d, FLIP | 16'h00a7, ABS | 16'd203, 16'd100);
        send_entry(16'h000e, REUSE | 16'h0011, ABS | 16'd305, 16'd200);
        send_entry(16'h000f, FLIP | REUSE, ABS | 16'd2, 16'd3);

        current_test = "random";
        for (n = 0; n < 3; n++) begin
            entry_rng = xorshift32(entry_rng);
            send_entry(16'h0100 + 16'(n), {7'd0, entry_rng[17], entry_rng[31:24]},
                       ABS | {7'd0, entry_rng[8:0]}, {8'd0, entry_rng[16:9]});
        end

        wait_drained();
        if (words_seen != WORDS_PER_SPRITE * sprites_drawn) begin
            other_errors++;
            $display("ERROR: %0d framebuffer writes seen for %0d drawn sprites",
                     words_seen, sprites_drawn);
        end
        if (tile_reqs != sprites_drawn) begin
            other_errors++;
            $display("ERROR: %0d tile requests for %0d drawn sprites", tile_reqs, sprites_drawn);
        end
        if (expected.size() != 0) begin
            other_errors++;
            $display("ERROR: %0d expected words were never written", expected.size());
        end
        finish_run();
    end

endmodule

// File: flist.f
logic/obj_pkg.sv
logic/obj_ifaces.sv
logic/obj_position_eval.sv
logic/obj_tile_store.sv
logic/obj_row_packer.sv
logic/obj_draw_ctrl.sv
logic/obj_engine.sv
sim/obj_engine_assertions.sv
sim/obj_engine_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the obj_engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module obj_engine_tb \
    --Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vobj_engine_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
